/* Bender.yml */
package:
  name: ecg_thr

sources:
  - files:
      - src/ecg_thr_pkg.sv
      - src/ecg_block_capture.sv
      - src/ecg_extreme_track.sv
      - src/ecg_threshold_calc.sv
      - src/ecg_thr_top.sv
  - target: test
    files:
      - bench/ecg_thr_tb.sv

/* bench/ecg_thr_tb.sv */
`timescale 1ns/1ps

module ecg_thr_tb
	import ecg_thr_pkg::*;
;

	localparam int LANES = 8;
	localparam int BLOCKS = 101;
	// blocks in a normal directed window
	localparam int WIN_BLOCKS = 20;
	// edges allowed for the extremes to settle
	localparam int SETTLE_LIMIT = 10;

	logic clk;
	logic nReset;
	logic enable;
	logic window_active;
	logic calc;
	sample_t samples [LANES];
	pos_t min_pos;
	pos_t max_pos;
	thr_t thr1;
	thr_t thr2;

	// stimulus blocks, room for the over-limit window
	int stim [BLOCKS + 3][LANES];
	// model extremes of the captured blocks
	int exp_max;
	int exp_min;
	// last thresholds predicted by the model
	int last_thr1;
	int last_thr2;
	logic [31:0] rng_state;
	string cur_test;
	int error_count;
	int errors_at_start;
	int tests_run;
	int tests_failed;

	ecg_thr_top #(
		.LANES(LANES),
		.BLOCKS(BLOCKS)
	) dut_i (
		.clk(clk),
		.nReset(nReset),
		.enable(enable),
		.window_active(window_active),
		.calc(calc),
		.samples(samples),
		.min_pos(min_pos),
		.max_pos(max_pos),
		.thr1(thr1),
		.thr2(thr2)
	);

	// 100 ns period
	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// |max - min| with the difference wrapped to 16 bits
	function automatic int swing_magnitude(input int hi, input int lo);
		int d;
		d = (hi - lo) & 32'hffff;
		return (d >= 32768) ? 65536 - d : d;
	endfunction

	// threshold from swing, slope and which output
	function automatic int threshold_model(input int mag, input bit rising, input bit first);
		int sh;
		int y;
		int s;
		if (mag > 4000)
			sh = rising ? (first ? 2 : 3) : (first ? 7 : 4);
		else if (mag > 2000)
			sh = rising ? (first ? 3 : 4) : (first ? 5 : 3);
		else
			sh = rising ? (first ? 6 : 3) : (first ? 5 : 3);
		y = mag >> sh;
		// about 1.83 times y, rounded up by one
		s = (y + (y >> 1) + (y >> 2) + (y >> 4) + (y >> 6) + (y >> 12) + 1) % 65536;
		if (rising && first && mag <= 2000)
			s = (s + 2) % 65536;
		return s;
	endfunction

	task automatic expect_equal(input string what, input int exp, input logic [31:0] act);
		assert (exp == act)
		else
		begin
			$display("Mismatch %s %s expected %0d actual %0d", cur_test, what, exp, act);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		errors_at_start = error_count;
		tests_run++;
	endtask

	task automatic report_test();
		if (error_count == errors_at_start)
			$display("[ok]  %s", cur_test);
		else
		begin
			$display("[bad] %s with %0d errors", cur_test, error_count - errors_at_start);
			tests_failed++;
		end
	endtask

	// random values in [base, base+swing], exact extremes forced in
	task automatic fill_band(input int n, input int base, input int swing);
		for (int b = 0; b < n; b++)
			for (int l = 0; l < LANES; l++)
			begin
				rng_state = xorshift(rng_state);
				stim[b][l] = base + int'(rng_state % (swing + 1));
			end
		stim[1][3] = base;
		stim[n - 2][6] = base + swing;
	endtask

	// one cycle of disable, then n blocks held two cycles each
	task automatic run_window(input int n);
		@(negedge clk);
		enable = 1'b0;
		window_active = 1'b0;
		@(negedge clk);
		enable = 1'b1;
		window_active = 1'b1;
		exp_max = -32768;
		exp_min = 32767;
		for (int b = 0; b < n; b++)
		begin
			for (int l = 0; l < LANES; l++)
			begin
				samples[l] = sample_t'(stim[b][l]);
				// blocks past the limit never reach the tracker
				if (b < BLOCKS)
				begin
					exp_max = (stim[b][l] > exp_max) ? stim[b][l] : exp_max;
					exp_min = (stim[b][l] < exp_min) ? stim[b][l] : exp_min;
				end
			end
			@(negedge clk);
			@(negedge clk);
		end
		window_active = 1'b0;
	endtask

	task automatic wait_extremes();
		bit settled;
		settled = 1'b0;
		for (int cyc = 0; cyc < SETTLE_LIMIT && !settled; cyc++)
		begin
			@(negedge clk);
			settled = (dut_i.track_i.win_max == exp_max) && (dut_i.track_i.win_min == exp_min);
		end
		assert (settled)
		else
		begin
			$display("%s: window extremes never reached the model values in time", cur_test);
			error_count++;
		end
	endtask

	// pulse calc, then compare both thresholds with the model
	task automatic calc_and_check(input int mn, input int mx);
		int mag;
		min_pos = pos_t'(mn);
		max_pos = pos_t'(mx);
		calc = 1'b1;
		@(negedge clk);
		calc = 1'b0;
		@(negedge clk);
		mag = swing_magnitude(exp_max, exp_min);
		last_thr1 = threshold_model(mag, mn < mx, 1'b1);
		last_thr2 = threshold_model(mag, mn < mx, 1'b0);
		expect_equal("thr1", last_thr1, thr1);
		expect_equal("thr2", last_thr2, thr2);
	endtask

	task automatic band_window(input int base, input int swing, input int mn, input int mx);
		fill_band(WIN_BLOCKS, base, swing);
		run_window(WIN_BLOCKS);
		wait_extremes();
		calc_and_check(mn, mx);
	endtask

	task automatic reset_values_hold();
		start_test("reset_values_hold");
		expect_equal("thr1", 0, thr1);
		expect_equal("thr2", 0, thr2);
		// a full window without calc leaves them cleared
		fill_band(WIN_BLOCKS, -1500, 5000);
		run_window(WIN_BLOCKS);
		wait_extremes();
		expect_equal("thr1", 0, thr1);
		expect_equal("thr2", 0, thr2);
		report_test();
	endtask

	task automatic rising_slope_bands();
		start_test("rising_slope_bands");
		band_window(-2000, 6000, 100, 400);
		band_window(500, 3000, 12, 700);
		band_window(-800, 1200, 0, 4095);
		// boundaries go to the lower band
		band_window(-4000, 4000, 300, 301);
		band_window(1000, 2000, 50, 60);
		report_test();
	endtask

	task automatic falling_slope_bands();
		start_test("falling_slope_bands");
		band_window(-5000, 9000, 400, 100);
		band_window(-100, 2500, 700, 12);
		band_window(300, 800, 20, 20);
		band_window(-2500, 4000, 4095, 0);
		band_window(-1000, 2000, 61, 60);
		report_test();
	endtask

	task automatic block_limit_ignores_outliers();
		start_test("block_limit_ignores_outliers");
		fill_band(BLOCKS, -700, 1400);
		// three late blocks at the rails
		for (int b = BLOCKS; b < BLOCKS + 3; b++)
			for (int l = 0; l < LANES; l++)
				stim[b][l] = l[0] ? 32767 : -32768;
		run_window(BLOCKS + 3);
		wait_extremes();
		calc_and_check(10, 800);
		report_test();
	endtask

	task automatic window_restart_clears();
		int hold1;
		int hold2;
		start_test("window_restart_clears");
		band_window(-3000, 7000, 40, 900);
		hold1 = last_thr1;
		hold2 = last_thr2;
		fill_band(WIN_BLOCKS, 200, 1500);
		run_window(WIN_BLOCKS);
		wait_extremes();
		// no calc yet, first window still shown
		expect_equal("thr1 hold", hold1, thr1);
		expect_equal("thr2 hold", hold2, thr2);
		calc_and_check(900, 40);
		report_test();
	endtask

	task automatic random_windows_match();
		int mn;
		int mx;
		int span;
		int base;
		start_test("random_windows_match");
		for (int w = 0; w < 5; w++)
		begin
			// random span, often narrow enough for the lower bands
			rng_state = xorshift(rng_state);
			span = int'((rng_state % 24001) >> rng_state[31:29]);
			// offset keeps every sample within +-12000
			rng_state = xorshift(rng_state);
			base = -12000 + int'(rng_state % (24001 - span));
			fill_band(WIN_BLOCKS, base, span);
			rng_state = xorshift(rng_state);
			mn = int'(rng_state[11:0]);
			rng_state = xorshift(rng_state);
			mx = int'(rng_state[11:0]);
			run_window(WIN_BLOCKS);
			wait_extremes();
			calc_and_check(mn, mx);
		end
		report_test();
	endtask

	initial
	begin
		clk = 1'b0;
		nReset = 1'b0;
		enable = 1'b0;
		window_active = 1'b0;
		calc = 1'b0;
		min_pos = '0;
		max_pos = '0;
		for (int l = 0; l < LANES; l++)
			samples[l] = '0;
		rng_state = 32'h82de70f6;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		nReset = 1'b1;
		reset_values_hold();
		rising_slope_bands();
		falling_slope_bands();
		block_limit_ignores_outliers();
		window_restart_clears();
		random_windows_match();
		$display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* project.f */
src/ecg_thr_pkg.sv
src/ecg_block_capture.sv
src/ecg_extreme_track.sv
src/ecg_threshold_calc.sv
src/ecg_thr_top.sv
bench/ecg_thr_tb.sv

/* src/ecg_block_capture.sv */
`timescale 1ns/1ps

module ecg_block_capture
	import ecg_thr_pkg::*;
#(
	parameter int LANES = 8,
	parameter int BLOCKS = 101
)
(
	input logic clk,
	input logic nReset,
	input logic enable,
	input logic window_active,
	input sample_t samples [LANES],
	output sample_t block [LANES],
	output logic block_valid
);

	// counter wide enough to hold BLOCKS itself
	localparam int CNT_W = $clog2(BLOCKS + 1);
	localparam logic [CNT_W-1:0] CNT_LIMIT = CNT_W'(BLOCKS);

	// alternating phase, a block is taken only on phase 1
	logic phase;

	// blocks taken in the current window
	logic [CNT_W-1:0] count;

	// this cycle's block is taken
	logic accept;

	assign accept = enable && window_active && phase && (count < CNT_LIMIT);

	// control state
	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			phase <= 1'b0;
			count <= '0;
			block_valid <= 1'b0;
		end
		else if (!enable)
		begin
			// disabled, restart from phase 0 with an empty count
			phase <= 1'b0;
			count <= '0;
			block_valid <= 1'b0;
		end
		else
		begin
			phase <= ~phase;
			// one-cycle pulse after each capture
			block_valid <= accept;
			if (!window_active)
			begin
				// window closed, next window starts counting again
				count <= '0;
			end
			else if (accept)
			begin
				count <= count + 1'b1;
			end
		end
	end

	// sample register, one block per accepted cycle
	always_ff @(posedge clk)
	begin
		if (!enable)
		begin
			block <= '{default: '0};
		end
		else if (accept)
		begin
			block <= samples;
		end
	end

	// counter saturates at BLOCKS, late blocks are dropped
	count_in_range: assert property (
		@(posedge clk) disable iff (!nReset)
		count <= CNT_LIMIT
	);

endmodule

/* src/ecg_extreme_track.sv */
`timescale 1ns/1ps

module ecg_extreme_track
	import ecg_thr_pkg::*;
#(
	// number of lanes, a power of two
	parameter int LANES = 8
)
(
	input logic clk,
	input logic nReset,
	input logic enable,
	input logic block_valid,
	input sample_t block [LANES],
	output sample_t win_max,
	output sample_t win_min
);

	// compare trees stored heap style
	// node 0 is the root, leaves sit at LANES-1 up to 2*LANES-2
	// children of node i are 2i+1 and 2i+2
	localparam int NODES = 2 * LANES - 1;

	sample_t max_node [NODES];
	sample_t min_node [NODES];

	// tree results for the current block
	sample_t blk_max;
	sample_t blk_min;

	// leaves take the block lanes directly
	for (genvar i = 0; i < LANES; i++)
	begin : g_leaf
		assign max_node[LANES - 1 + i] = block[i];
		assign min_node[LANES - 1 + i] = block[i];
	end

	// inner nodes, one pairwise compare each
	// balanced for a power-of-two LANES, log2(LANES) levels deep
	for (genvar i = 0; i < LANES - 1; i++)
	begin : g_node
		assign max_node[i] = (max_node[2*i + 1] >= max_node[2*i + 2]) ?
			max_node[2*i + 1] : max_node[2*i + 2];
		assign min_node[i] = (min_node[2*i + 1] <= min_node[2*i + 2]) ?
			min_node[2*i + 1] : min_node[2*i + 2];
	end

	assign blk_max = max_node[0];
	assign blk_min = min_node[0];

	// running extremes of the window
	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			win_max <= SAMPLE_MIN;
			win_min <= SAMPLE_MAX;
		end
		else if (!enable)
		begin
			// new window starts from the opposite rails
			win_max <= SAMPLE_MIN;
			win_min <= SAMPLE_MAX;
		end
		else if (block_valid)
		begin
			// fold the block into the window
			if (blk_max > win_max)
			begin
				win_max <= blk_max;
			end
			if (blk_min < win_min)
			begin
				win_min <= blk_min;
			end
		end
	end

	// once a block is folded in the extremes are ordered
	// a pulse that meets a disable is dropped, so it is not checked
	extremes_ordered: assert property (
		@(posedge clk) disable iff (!nReset)
		(enable && block_valid) |=> (win_max >= win_min)
	);

endmodule

/* src/ecg_thr_pkg.sv */
package ecg_thr_pkg;

	// one signed ecg sample from the adc front end
	typedef logic signed [15:0] sample_t;

	// unsigned threshold, also used for the swing magnitude
	typedef logic [15:0] thr_t;

	// sample position inside the window, from the peak locator
	typedef logic [11:0] pos_t;

	// pre-shift amount, max shift in the table is 7
	typedef logic [2:0] shift_t;

	// swing bands, upper band wins on overlap
	typedef enum logic [1:0]
	{
		BAND_SMALL,
		BAND_MID,
		BAND_BIG
	} band_t;

	// band limits, compares are strictly greater
	localparam thr_t BIG_SWING = 16'd4000;
	localparam thr_t MID_SWING = 16'd2000;

	// start values for the running extremes
	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

	// extra offset on thr1, rising slope with small swing only
	localparam thr_t SMALL_RISE_BIAS = 16'd2;

	// pre-shift table, rising slope (min before max)
	localparam shift_t RISE_BIG_SH1 = 3'd2;
	localparam shift_t RISE_BIG_SH2 = 3'd3;
	localparam shift_t RISE_MID_SH1 = 3'd3;
	localparam shift_t RISE_MID_SH2 = 3'd4;
	localparam shift_t RISE_SMALL_SH1 = 3'd6;
	localparam shift_t RISE_SMALL_SH2 = 3'd3;

	// pre-shift table, falling slope (min after max)
	localparam shift_t FALL_BIG_SH1 = 3'd7;
	localparam shift_t FALL_BIG_SH2 = 3'd4;
	localparam shift_t FALL_MID_SH1 = 3'd5;
	localparam shift_t FALL_MID_SH2 = 3'd3;
	localparam shift_t FALL_SMALL_SH1 = 3'd5;
	localparam shift_t FALL_SMALL_SH2 = 3'd3;

	// shift-and-add scale of roughly 1.83
	// 1 + 1/2 + 1/4 + 1/16 + 1/64 + 1/4096, plus one for rounding
	// everything wraps in 16 bits, shifts are logical
	function automatic thr_t scaled(input thr_t y);
		return y + (y >> 1) + (y >> 2) + (y >> 4) + (y >> 6) + (y >> 12) + 16'd1;
	endfunction

endpackage

/* src/ecg_thr_top.sv */
`timescale 1ns/1ps

module ecg_thr_top
	import ecg_thr_pkg::*;
#(
	// samples per block
	parameter int LANES = 8,
	// blocks per window, 808 samples by default
	parameter int BLOCKS = 101
)
(
	input logic clk,
	input logic nReset,
	input logic enable,
	input logic window_active,
	input logic calc,
	input sample_t samples [LANES],
	input pos_t min_pos,
	input pos_t max_pos,
	output thr_t thr1,
	output thr_t thr2
);

	// capture to tracker
	sample_t block [LANES];
	logic block_valid;

	// tracker to calc
	sample_t win_max;
	sample_t win_min;

	// decode, gates and registers the incoming blocks
	ecg_block_capture #(
		.LANES(LANES),
		.BLOCKS(BLOCKS)
	) capture_i (
		.clk(clk),
		.nReset(nReset),
		.enable(enable),
		.window_active(window_active),
		.samples(samples),
		.block(block),
		.block_valid(block_valid)
	);

	// execute, window max and min
	ecg_extreme_track #(
		.LANES(LANES)
	) track_i (
		.clk(clk),
		.nReset(nReset),
		.enable(enable),
		.block_valid(block_valid),
		.block(block),
		.win_max(win_max),
		.win_min(win_min)
	);

	// result, swing to thresholds
	ecg_threshold_calc calc_i (
		.clk(clk),
		.nReset(nReset),
		.calc(calc),
		.win_max(win_max),
		.win_min(win_min),
		.min_pos(min_pos),
		.max_pos(max_pos),
		.thr1(thr1),
		.thr2(thr2)
	);

endmodule

/* src/ecg_threshold_calc.sv */
`timescale 1ns/1ps

module ecg_threshold_calc
	import ecg_thr_pkg::*;
(
	input logic clk,
	input logic nReset,
	input logic calc,
	input sample_t win_max,
	input sample_t win_min,
	input pos_t min_pos,
	input pos_t max_pos,
	output thr_t thr1,
	output thr_t thr2
);

	// raw difference and its magnitude, both 16 bits
	thr_t diff;
	thr_t mag;

	// band of the swing and slope direction
	band_t band;
	logic rising;

	// selected pre-shifts and the thr1 offset
	shift_t sh1;
	shift_t sh2;
	thr_t bias;

	// difference wraps in 16 bits like the sample path
	assign diff = thr_t'(win_max - win_min);

	// two's complement magnitude
	assign mag = diff[15] ? thr_t'(~diff + 16'd1) : diff;

	// min before max means a rising slope
	assign rising = (min_pos < max_pos);

	// band select, boundary values drop to the lower band
	always_comb
	begin
		if (mag > BIG_SWING)
		begin
			band = BAND_BIG;
		end
		else if (mag > MID_SWING)
		begin
			band = BAND_MID;
		end
		else
		begin
			band = BAND_SMALL;
		end
	end

	// shift table lookup
	always_comb
	begin
		bias = '0;
		if (rising)
		begin
			case (band)
				BAND_BIG:
				begin
					sh1 = RISE_BIG_SH1;
					sh2 = RISE_BIG_SH2;
				end
				BAND_MID:
				begin
					sh1 = RISE_MID_SH1;
					sh2 = RISE_MID_SH2;
				end
				default:
				begin
					sh1 = RISE_SMALL_SH1;
					sh2 = RISE_SMALL_SH2;
					// small rising swing gets a floor offset
					bias = SMALL_RISE_BIAS;
				end
			endcase
		end
		else
		begin
			case (band)
				BAND_BIG:
				begin
					sh1 = FALL_BIG_SH1;
					sh2 = FALL_BIG_SH2;
				end
				BAND_MID:
				begin
					sh1 = FALL_MID_SH1;
					sh2 = FALL_MID_SH2;
				end
				default:
				begin
					sh1 = FALL_SMALL_SH1;
					sh2 = FALL_SMALL_SH2;
				end
			endcase
		end
	end

	// thresholds load on calc and hold otherwise
	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			thr1 <= '0;
			thr2 <= '0;
		end
		else if (calc)
		begin
			thr1 <= scaled(mag >> sh1) + bias;
			thr2 <= scaled(mag >> sh2);
		end
	end

	// calc decides whether the thresholds move
	calc_known: assert property (
		@(posedge clk) disable iff (!nReset)
		!$isunknown(calc)
	);

endmodule
